// ==== tb/biu_tests.txt ====
# name lsu_v ifu_v lsu_addr lsu_rd lsu_wdata lsu_wmask ifu_addr ifu_rd ifu_wdata ifu_wmask
#   enables(b0 ppi b1 clint b2 plic) lsu_tgt ifu_tgt rdata ifu_err  (tgt 0 mem 1 plic 2 clint 3 ppi 4 err)
lsu_ppi         1 0 10000040 0 cafe0001 f 00000000 0 00000000 0 7 3 0 11112222 0
lsu_clint       1 0 0200bff8 1 00000000 0 00000000 0 00000000 0 7 2 0 33334444 0
lsu_plic        1 0 0c200004 0 12345678 3 00000000 0 00000000 0 7 1 0 55556666 0
lsu_mem         1 0 80001000 1 00000000 0 00000000 0 00000000 0 7 0 0 77778888 0
lsu_ppi_off     1 0 1000ff00 1 00000000 0 00000000 0 00000000 0 6 0 0 9999aaaa 0
lsu_clint_off   1 0 02000010 0 a5a5a5a5 c 00000000 0 00000000 0 5 0 0 bbbbcccc 0
lsu_plic_off    1 0 0c000100 1 00000000 0 00000000 0 00000000 0 3 0 0 ddddeeee 0
lsu_all_off     1 0 1c000000 0 0f0f0f0f 1 00000000 0 00000000 0 0 0 0 01020304 0
ifu_ppi         0 1 00000000 0 00000000 0 10000000 1 00000000 0 7 0 4 deadbeef 1
ifu_clint       0 1 00000000 0 00000000 0 0200c000 1 00000000 0 7 0 4 deadbeef 1
ifu_plic        0 1 00000000 0 00000000 0 0c000004 1 00000000 0 7 0 4 deadbeef 1
ifu_mem         0 1 00000000 0 00000000 0 80000000 1 00000000 0 7 0 0 00000013 0
ifu_ppi_off     0 1 00000000 0 00000000 0 10000800 1 00000000 0 6 0 0 00100093 0
both_mem        1 1 80000010 1 00000000 0 80000020 1 00000000 0 7 0 0 aabbccdd 0
both_ppi_mem    1 1 10000004 0 87654321 f 80000100 1 00000000 0 7 3 0 0badf00d 0
both_clint_err  1 1 02004000 1 00000000 0 0c000000 1 00000000 0 7 2 4 13572468 1
both_plic_ppi   1 1 0c002000 0 00ff00ff 5 10004000 1 00000000 0 7 1 4 24681357 1

// ==== sources.f ====
hdl/biu_pkg.sv
hdl/biu_pipe_stage.sv
hdl/biu_arbiter.sv
hdl/biu_buffer.sv
hdl/biu_splitter.sv
hdl/biu_top.sv
tb/tb_biu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BIU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_biu -f sources.f -o tb_biu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_biu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
  exit 0
fi
echo "Simulation reported failures"
exit 1

// ==== tb/tb_biu.sv ====
// Testbench for biu_top with file-driven tests, random-latency target models and watchdog
`timescale 1ns/1ps

module tb_biu import biu_pkg::*; ();

  localparam int          MAX_TESTS = 32;
  localparam logic [31:0] SEED      = 32'ha7cc_9cab;
  localparam logic [31:0] PPI_BASE  = 32'h1000_0000;
  localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
  localparam logic [31:0] PLIC_BASE = 32'h0c00_0000;

  logic     clk = 1'b0;
  logic     arst_n = 1'b0;
  logic     lsu_valid = 1'b0;
  logic     ifu_valid = 1'b0;
  icb_cmd_t lsu_cmd = '0;
  icb_cmd_t ifu_cmd = '0;
  logic     lsu_rsp_ready = 1'b0;
  logic     ifu_rsp_ready = 1'b0;
  logic     ppi_en = 1'b1;
  logic     clint_en = 1'b1;
  logic     plic_en = 1'b1;
  logic [DATA_W-1:0] cur_rdata = '0;

  logic     lsu_cmd_ready;
  logic     ifu_cmd_ready;
  logic     lsu_rsp_valid;
  logic     ifu_rsp_valid;
  icb_rsp_t lsu_rsp;
  icb_rsp_t ifu_rsp;
  logic     biu_active;

  // Target side, index follows target_e (MEM, PLIC, CLINT, PPI)
  logic [3:0] t_cmd_valid;
  logic [3:0] t_cmd_ready = '0;
  logic [3:0] t_rsp_valid = '0;
  logic [3:0] t_rsp_ready;
  icb_cmd_t   t_cmd [4];
  icb_rsp_t   t_rsp [4] = '{default: '0};
  int         t_state [4] = '{default: 0};
  int         t_delay [4] = '{default: 0};

  // Commands seen at the targets
  target_e  cap_tgt [$];
  icb_cmd_t cap_cmd [$];
  int       cap_cyc [$];
  int       route_errs = 0;
  int       cycle = 0;

  // Test table
  string             t_name [MAX_TESTS];
  bit                t_lv [MAX_TESTS];
  bit                t_iv [MAX_TESTS];
  icb_cmd_t          t_lcmd [MAX_TESTS];
  icb_cmd_t          t_icmd [MAX_TESTS];
  logic [2:0]        t_en [MAX_TESTS];
  target_e           t_lt [MAX_TESTS];
  target_e           t_it [MAX_TESTS];
  logic [DATA_W-1:0] t_rdata [MAX_TESTS];
  bit                t_err [MAX_TESTS];
  int                ntests = 0;
  int                errors = 0;
  int                failed = 0;
  int                limit = 0;
  string             cur_name = "setup";

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  biu_top u_biu_top (
    .clk               (clk),
    .i_arst_n          (arst_n),
    .o_biu_active      (biu_active),
    .i_lsu_cmd_valid   (lsu_valid),
    .o_lsu_cmd_ready   (lsu_cmd_ready),
    .i_lsu_cmd         (lsu_cmd),
    .o_lsu_rsp_valid   (lsu_rsp_valid),
    .i_lsu_rsp_ready   (lsu_rsp_ready),
    .o_lsu_rsp         (lsu_rsp),
    .i_ifu_cmd_valid   (ifu_valid),
    .o_ifu_cmd_ready   (ifu_cmd_ready),
    .i_ifu_cmd         (ifu_cmd),
    .o_ifu_rsp_valid   (ifu_rsp_valid),
    .i_ifu_rsp_ready   (ifu_rsp_ready),
    .o_ifu_rsp         (ifu_rsp),
    .i_ppi_region      (PPI_BASE),
    .i_ppi_enable      (ppi_en),
    .i_clint_region    (CLINT_BASE),
    .i_clint_enable    (clint_en),
    .i_plic_region     (PLIC_BASE),
    .i_plic_enable     (plic_en),
    .o_ppi_cmd_valid   (t_cmd_valid[3]),
    .i_ppi_cmd_ready   (t_cmd_ready[3]),
    .o_ppi_cmd         (t_cmd[3]),
    .i_ppi_rsp_valid   (t_rsp_valid[3]),
    .o_ppi_rsp_ready   (t_rsp_ready[3]),
    .i_ppi_rsp         (t_rsp[3]),
    .o_clint_cmd_valid (t_cmd_valid[2]),
    .i_clint_cmd_ready (t_cmd_ready[2]),
    .o_clint_cmd       (t_cmd[2]),
    .i_clint_rsp_valid (t_rsp_valid[2]),
    .o_clint_rsp_ready (t_rsp_ready[2]),
    .i_clint_rsp       (t_rsp[2]),
    .o_plic_cmd_valid  (t_cmd_valid[1]),
    .i_plic_cmd_ready  (t_cmd_ready[1]),
    .o_plic_cmd        (t_cmd[1]),
    .i_plic_rsp_valid  (t_rsp_valid[1]),
    .o_plic_rsp_ready  (t_rsp_ready[1]),
    .i_plic_rsp        (t_rsp[1]),
    .o_mem_cmd_valid   (t_cmd_valid[0]),
    .i_mem_cmd_ready   (t_cmd_ready[0]),
    .o_mem_cmd         (t_cmd[0]),
    .i_mem_rsp_valid   (t_rsp_valid[0]),
    .o_mem_rsp_ready   (t_rsp_ready[0]),
    .i_mem_rsp         (t_rsp[0])
  );

  ////////////////////////////////////////////////////////////
  // Target models with random ready and answer delay
  always @(posedge clk) begin
    if (arst_n) begin
      if ($countones(t_cmd_valid) > 1) begin
        route_errs <= route_errs + 1;
      end
      for (int k = 0; k < 4; k++) begin
        case (t_state[k])
          0: begin
            if (t_cmd_valid[k] && t_cmd_ready[k]) begin
              cap_tgt.push_back(target_e'(k[2:0]));
              cap_cmd.push_back(t_cmd[k]);
              cap_cyc.push_back(cycle);
              t_cmd_ready[k] <= 1'b0;
              t_delay[k]     <= $urandom % 4;
              t_state[k]     <= 1;
            end else begin
              t_cmd_ready[k] <= ($urandom % 2 == 0);
            end
          end
          1: begin
            if (t_delay[k] == 0) begin
              t_rsp_valid[k] <= 1'b1;
              t_rsp[k]       <= '{err: 1'b0, rdata: cur_rdata};
              t_state[k]     <= 2;
            end else begin
              t_delay[k] <= t_delay[k] - 1;
            end
          end
          default: begin
            if (t_rsp_ready[k]) begin
              t_rsp_valid[k] <= 1'b0;
              t_state[k]     <= 0;
            end
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare and report helpers
  task automatic report_fault(input string msg);
    $display("%s: %s", cur_name, msg);
    errors++;
  endtask

  task automatic check_cmd(input string what, input icb_cmd_t exp, input icb_cmd_t act);
    if (exp !== act) begin
      $display("ERR %s %s exp %h act %h", cur_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_rsp(input string what, input icb_rsp_t exp, input icb_rsp_t act);
    if (exp !== act) begin
      $display("ERR %s %s exp %h act %h", cur_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_target(input string what, input target_e exp, input target_e act);
    if (exp !== act) begin
      $display("ERR %s %s exp %s act %s", cur_name, what, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    int          lv;
    int          iv;
    int          lrd;
    int          ird;
    int          en;
    int          lt;
    int          it;
    int          er;
    string       line;
    string       name;
    logic [31:0] la;
    logic [31:0] lw;
    logic [31:0] lm;
    logic [31:0] ia;
    logic [31:0] iw;
    logic [31:0] im;
    logic [31:0] rd;
    fd = $fopen("tb/biu_tests.txt", "r");
    if (fd == 0) begin
      report_fault("cannot open tb/biu_tests.txt");
      return;
    end
    while (!$feof(fd) && ntests < MAX_TESTS) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %d %d %h %d %h %h %h %d %h %h %d %d %d %h %d",
                  name, lv, iv, la, lrd, lw, lm, ia, ird, iw, im, en, lt, it, rd, er);
      if (n != 16) begin
        report_fault("malformed line in test file");
        continue;
      end
      t_name[ntests]  = name;
      t_lv[ntests]    = (lv != 0);
      t_iv[ntests]    = (iv != 0);
      t_lcmd[ntests]  = '{addr: la, read: (lrd != 0), wdata: lw, wmask: lm[MASK_W-1:0]};
      t_icmd[ntests]  = '{addr: ia, read: (ird != 0), wdata: iw, wmask: im[MASK_W-1:0]};
      t_en[ntests]    = en[2:0];
      t_lt[ntests]    = target_e'(lt[2:0]);
      t_it[ntests]    = target_e'(it[2:0]);
      t_rdata[ntests] = rd;
      t_err[ntests]   = (er != 0);
      ntests++;
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // One test: drive both masters, wait for responses, then check
  task automatic run_test(input int i);
    icb_rsp_t lrsp;
    icb_rsp_t irsp;
    icb_rsp_t iexp;
    int       base;
    int       k;
    int       lcyc;
    int       icyc;
    int       nexp;
    int       errs0;
    int       route0;
    bit       ldone;
    bit       idone;
    cur_name = t_name[i];
    errs0    = errors;
    route0   = route_errs;
    base     = cap_tgt.size();
    ldone    = !t_lv[i];
    idone    = !t_iv[i];
    lrsp     = '0;
    irsp     = '0;
    lcyc     = 0;
    icyc     = 0;
    @(posedge clk);
    ppi_en    <= t_en[i][0];
    clint_en  <= t_en[i][1];
    plic_en   <= t_en[i][2];
    cur_rdata <= t_rdata[i];
    lsu_cmd   <= t_lcmd[i];
    ifu_cmd   <= t_icmd[i];
    lsu_valid <= t_lv[i];
    ifu_valid <= t_iv[i];
    while (!(ldone && idone)) begin
      @(posedge clk);
      if (lsu_valid && lsu_cmd_ready) begin
        lsu_valid <= 1'b0;
      end
      if (ifu_valid && ifu_cmd_ready) begin
        ifu_valid <= 1'b0;
      end
      if (lsu_rsp_valid && lsu_rsp_ready) begin
        if (ldone) begin
          report_fault("unexpected response at the LSU");
        end
        lrsp  = lsu_rsp;
        lcyc  = cycle;
        ldone = 1'b1;
        if (biu_active !== 1'b1) begin
          report_fault("activity flag low during an outstanding LSU transaction");
        end
      end
      if (ifu_rsp_valid && ifu_rsp_ready) begin
        if (idone) begin
          report_fault("unexpected response at the IFU");
        end
        irsp  = ifu_rsp;
        icyc  = cycle;
        idone = 1'b1;
        if (biu_active !== 1'b1) begin
          report_fault("activity flag low during an outstanding IFU transaction");
        end
      end
      lsu_rsp_ready <= ($urandom % 2 == 0);
      ifu_rsp_ready <= ($urandom % 2 == 0);
    end
    @(posedge clk);
    if (biu_active !== 1'b0) begin
      report_fault("activity flag still high after the test drained");
    end

    nexp = int'(t_lv[i]) + int'(t_iv[i] && t_it[i] != TGT_IFUERR);
    if (cap_tgt.size() - base != nexp) begin
      report_fault("wrong number of commands reached the targets");
    end else begin
      k = base;
      if (t_lv[i]) begin
        check_target("lsu target", t_lt[i], cap_tgt[k]);
        check_cmd("lsu cmd", t_lcmd[i], cap_cmd[k]);
        k++;
      end
      if (t_iv[i] && t_it[i] != TGT_IFUERR) begin
        check_target("ifu target", t_it[i], cap_tgt[k]);
        check_cmd("ifu cmd", t_icmd[i], cap_cmd[k]);
        if (t_lv[i] && cap_cyc[k] <= lcyc) begin
          report_fault("IFU command reached a target before the LSU response");
        end
      end
    end
    if (t_lv[i]) begin
      check_rsp("lsu rsp", '{err: 1'b0, rdata: t_rdata[i]}, lrsp);
    end
    if (t_iv[i]) begin
      iexp = t_err[i] ? '{err: 1'b1, rdata: '0} : '{err: 1'b0, rdata: t_rdata[i]};
      check_rsp("ifu rsp", iexp, irsp);
      if (t_lv[i] && icyc <= lcyc) begin
        report_fault("IFU response arrived before the LSU response");
      end
    end
    if (route_errs != route0) begin
      report_fault("more than one target saw a command at once");
    end

    if (errors == errs0) begin
      $display("PASS %s", cur_name);
    end else begin
      $display("FAIL %s", cur_name);
      failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog, sized from the number of tests
  initial begin
    wait (limit != 0);
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    load_tests();
    limit = ntests * 40 + 10;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    if (biu_active !== 1'b0 || t_cmd_valid !== 4'b0 || lsu_rsp_valid || ifu_rsp_valid) begin
      report_fault("outputs not idle after reset");
    end
    if (ntests == 0) begin
      report_fault("no tests were loaded");
    end
    for (int i = 0; i < ntests; i++) begin
      run_test(i);
    end
    $display("Tests %0d, failed %0d, errors %0d", ntests, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/biu_top.sv ====
// Bus interface unit top level with arbiter, buffer, splitter and target ports
`timescale 1ns/1ps

module biu_top import biu_pkg::*; (
  input  logic              clk,
  input  logic              i_arst_n,
  output logic              o_biu_active,
  // LSU master
  input  logic              i_lsu_cmd_valid,
  output logic              o_lsu_cmd_ready,
  input  icb_cmd_t          i_lsu_cmd,
  output logic              o_lsu_rsp_valid,
  input  logic              i_lsu_rsp_ready,
  output icb_rsp_t          o_lsu_rsp,
  // IFU master
  input  logic              i_ifu_cmd_valid,
  output logic              o_ifu_cmd_ready,
  input  icb_cmd_t          i_ifu_cmd,
  output logic              o_ifu_rsp_valid,
  input  logic              i_ifu_rsp_ready,
  output icb_rsp_t          o_ifu_rsp,
  // Region bases and enables
  input  logic [ADDR_W-1:0] i_ppi_region,
  input  logic              i_ppi_enable,
  input  logic [ADDR_W-1:0] i_clint_region,
  input  logic              i_clint_enable,
  input  logic [ADDR_W-1:0] i_plic_region,
  input  logic              i_plic_enable,
  // PPI target
  output logic              o_ppi_cmd_valid,
  input  logic              i_ppi_cmd_ready,
  output icb_cmd_t          o_ppi_cmd,
  input  logic              i_ppi_rsp_valid,
  output logic              o_ppi_rsp_ready,
  input  icb_rsp_t          i_ppi_rsp,
  // CLINT target
  output logic              o_clint_cmd_valid,
  input  logic              i_clint_cmd_ready,
  output icb_cmd_t          o_clint_cmd,
  input  logic              i_clint_rsp_valid,
  output logic              o_clint_rsp_ready,
  input  icb_rsp_t          i_clint_rsp,
  // PLIC target
  output logic              o_plic_cmd_valid,
  input  logic              i_plic_cmd_ready,
  output icb_cmd_t          o_plic_cmd,
  input  logic              i_plic_rsp_valid,
  output logic              o_plic_rsp_ready,
  input  icb_rsp_t          i_plic_rsp,
  // Main memory target
  output logic              o_mem_cmd_valid,
  input  logic              i_mem_cmd_ready,
  output icb_cmd_t          o_mem_cmd,
  input  logic              i_mem_rsp_valid,
  output logic              o_mem_rsp_ready,
  input  icb_rsp_t          i_mem_rsp
);

  // Arbiter to buffer
  logic         arb_cmd_valid;
  logic         arb_cmd_ready;
  icb_cmd_usr_t arb_cmd;
  logic         arb_rsp_valid;
  logic         arb_rsp_ready;
  icb_rsp_t     arb_rsp;

  // Buffer to splitter
  logic         buf_cmd_valid;
  logic         buf_cmd_ready;
  icb_cmd_usr_t buf_cmd;
  logic         buf_rsp_valid;
  logic         buf_rsp_ready;
  icb_rsp_t     buf_rsp;
  logic         buf_active;

  ////////////////////////////////////////////////////////////
  biu_arbiter u_arbiter (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_lsu_cmd_valid (i_lsu_cmd_valid),
    .o_lsu_cmd_ready (o_lsu_cmd_ready),
    .i_lsu_cmd       (i_lsu_cmd),
    .o_lsu_rsp_valid (o_lsu_rsp_valid),
    .i_lsu_rsp_ready (i_lsu_rsp_ready),
    .o_lsu_rsp       (o_lsu_rsp),
    .i_ifu_cmd_valid (i_ifu_cmd_valid),
    .o_ifu_cmd_ready (o_ifu_cmd_ready),
    .i_ifu_cmd       (i_ifu_cmd),
    .o_ifu_rsp_valid (o_ifu_rsp_valid),
    .i_ifu_rsp_ready (i_ifu_rsp_ready),
    .o_ifu_rsp       (o_ifu_rsp),
    .o_cmd_valid     (arb_cmd_valid),
    .i_cmd_ready     (arb_cmd_ready),
    .o_cmd           (arb_cmd),
    .i_rsp_valid     (arb_rsp_valid),
    .o_rsp_ready     (arb_rsp_ready),
    .i_rsp           (arb_rsp)
  );

  biu_buffer u_buffer (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_cmd_valid (arb_cmd_valid),
    .o_cmd_ready (arb_cmd_ready),
    .i_cmd       (arb_cmd),
    .o_rsp_valid (arb_rsp_valid),
    .i_rsp_ready (arb_rsp_ready),
    .o_rsp       (arb_rsp),
    .o_cmd_valid (buf_cmd_valid),
    .i_cmd_ready (buf_cmd_ready),
    .o_cmd       (buf_cmd),
    .i_rsp_valid (buf_rsp_valid),
    .o_rsp_ready (buf_rsp_ready),
    .i_rsp       (buf_rsp),
    .o_active    (buf_active)
  );

  biu_splitter u_splitter (
    .clk               (clk),
    .i_arst_n          (i_arst_n),
    .i_cmd_valid       (buf_cmd_valid),
    .o_cmd_ready       (buf_cmd_ready),
    .i_cmd             (buf_cmd),
    .o_rsp_valid       (buf_rsp_valid),
    .i_rsp_ready       (buf_rsp_ready),
    .o_rsp             (buf_rsp),
    .i_ppi_region      (i_ppi_region),
    .i_ppi_enable      (i_ppi_enable),
    .i_clint_region    (i_clint_region),
    .i_clint_enable    (i_clint_enable),
    .i_plic_region     (i_plic_region),
    .i_plic_enable     (i_plic_enable),
    .o_ppi_cmd_valid   (o_ppi_cmd_valid),
    .i_ppi_cmd_ready   (i_ppi_cmd_ready),
    .o_ppi_cmd         (o_ppi_cmd),
    .i_ppi_rsp_valid   (i_ppi_rsp_valid),
    .o_ppi_rsp_ready   (o_ppi_rsp_ready),
    .i_ppi_rsp         (i_ppi_rsp),
    .o_clint_cmd_valid (o_clint_cmd_valid),
    .i_clint_cmd_ready (i_clint_cmd_ready),
    .o_clint_cmd       (o_clint_cmd),
    .i_clint_rsp_valid (i_clint_rsp_valid),
    .o_clint_rsp_ready (o_clint_rsp_ready),
    .i_clint_rsp       (i_clint_rsp),
    .o_plic_cmd_valid  (o_plic_cmd_valid),
    .i_plic_cmd_ready  (i_plic_cmd_ready),
    .o_plic_cmd        (o_plic_cmd),
    .i_plic_rsp_valid  (i_plic_rsp_valid),
    .o_plic_rsp_ready  (o_plic_rsp_ready),
    .i_plic_rsp        (i_plic_rsp),
    .o_mem_cmd_valid   (o_mem_cmd_valid),
    .i_mem_cmd_ready   (i_mem_cmd_ready),
    .o_mem_cmd         (o_mem_cmd),
    .i_mem_rsp_valid   (i_mem_rsp_valid),
    .o_mem_rsp_ready   (o_mem_rsp_ready),
    .i_mem_rsp         (i_mem_rsp)
  );

  // Busy while a master asks or anything sits in the buffer
  assign o_biu_active = i_lsu_cmd_valid | i_ifu_cmd_valid | buf_active;

endmodule

// ==== hdl/biu_splitter.sv ====
// Region decode, target routing, IFU peripheral-error responder and response merge
`timescale 1ns/1ps

module biu_splitter import biu_pkg::*; (
  input  logic              clk,
  input  logic              i_arst_n,
  // From the buffer
  input  logic              i_cmd_valid,
  output logic              o_cmd_ready,
  input  icb_cmd_usr_t      i_cmd,
  output logic              o_rsp_valid,
  input  logic              i_rsp_ready,
  output icb_rsp_t          o_rsp,
  // Region bases and enables
  input  logic [ADDR_W-1:0] i_ppi_region,
  input  logic              i_ppi_enable,
  input  logic [ADDR_W-1:0] i_clint_region,
  input  logic              i_clint_enable,
  input  logic [ADDR_W-1:0] i_plic_region,
  input  logic              i_plic_enable,
  // PPI target
  output logic              o_ppi_cmd_valid,
  input  logic              i_ppi_cmd_ready,
  output icb_cmd_t          o_ppi_cmd,
  input  logic              i_ppi_rsp_valid,
  output logic              o_ppi_rsp_ready,
  input  icb_rsp_t          i_ppi_rsp,
  // CLINT target
  output logic              o_clint_cmd_valid,
  input  logic              i_clint_cmd_ready,
  output icb_cmd_t          o_clint_cmd,
  input  logic              i_clint_rsp_valid,
  output logic              o_clint_rsp_ready,
  input  icb_rsp_t          i_clint_rsp,
  // PLIC target
  output logic              o_plic_cmd_valid,
  input  logic              i_plic_cmd_ready,
  output icb_cmd_t          o_plic_cmd,
  input  logic              i_plic_rsp_valid,
  output logic              o_plic_rsp_ready,
  input  icb_rsp_t          i_plic_rsp,
  // Main memory, catches everything unmatched
  output logic              o_mem_cmd_valid,
  input  logic              i_mem_cmd_ready,
  output icb_cmd_t          o_mem_cmd,
  input  logic              i_mem_rsp_valid,
  output logic              o_mem_rsp_ready,
  input  icb_rsp_t          i_mem_rsp
);

  logic [ADDR_W-1:0]      addr;
  logic                   hit_ppi;
  logic                   hit_plic;
  logic                   hit_clint;
  target_e                cmd_sel;
  target_e                sel_q;
  target_e                rsp_sel;
  logic                   busy;
  logic                   cmd_go;
  logic                   rsp_live;
  logic                   cmd_xfer;
  logic                   rsp_xfer;
  logic                   err_rsp_valid;
  logic [NUM_TARGETS-1:0] tgt_cmd_ready;
  logic [NUM_TARGETS-1:0] tgt_rsp_valid;
  icb_rsp_t               tgt_rsp [NUM_TARGETS];

  ////////////////////////////////////////////////////////////
  // Region decode
  assign addr = i_cmd.cmd.addr;

  assign hit_ppi   = i_ppi_enable &
                     (addr[ADDR_W-1 -: PPI_MATCH_W] == i_ppi_region[ADDR_W-1 -: PPI_MATCH_W]);
  assign hit_plic  = i_plic_enable &
                     (addr[ADDR_W-1 -: PLIC_MATCH_W] == i_plic_region[ADDR_W-1 -: PLIC_MATCH_W]);
  assign hit_clint = i_clint_enable &
                     (addr[ADDR_W-1 -: CLINT_MATCH_W] ==
                      i_clint_region[ADDR_W-1 -: CLINT_MATCH_W]);

  // IFU must never reach a peripheral
  always_comb begin
    if (i_cmd.ifu && (hit_ppi || hit_plic || hit_clint)) begin
      cmd_sel = TGT_IFUERR;
    end else if (hit_ppi) begin
      cmd_sel = TGT_PPI;
    end else if (hit_plic) begin
      cmd_sel = TGT_PLIC;
    end else if (hit_clint) begin
      cmd_sel = TGT_CLINT;
    end else begin
      cmd_sel = TGT_MEM;
    end
  end

  ////////////////////////////////////////////////////////////
  // Command routing
  assign cmd_go = i_cmd_valid & ~busy;

  // Error responder takes the command when the response can leave
  assign tgt_cmd_ready = {i_rsp_ready, i_ppi_cmd_ready, i_clint_cmd_ready,
                          i_plic_cmd_ready, i_mem_cmd_ready};

  assign o_cmd_ready = ~busy & tgt_cmd_ready[cmd_sel];
  assign cmd_xfer    = i_cmd_valid & o_cmd_ready;

  assign o_ppi_cmd_valid   = cmd_go & (cmd_sel == TGT_PPI);
  assign o_clint_cmd_valid = cmd_go & (cmd_sel == TGT_CLINT);
  assign o_plic_cmd_valid  = cmd_go & (cmd_sel == TGT_PLIC);
  assign o_mem_cmd_valid   = cmd_go & (cmd_sel == TGT_MEM);

  assign o_ppi_cmd   = i_cmd.cmd;
  assign o_clint_cmd = i_cmd.cmd;
  assign o_plic_cmd  = i_cmd.cmd;
  assign o_mem_cmd   = i_cmd.cmd;

  ////////////////////////////////////////////////////////////
  // Response merge

  // Zero-cycle answer, error set and no data
  assign err_rsp_valid       = cmd_go & (cmd_sel == TGT_IFUERR);
  assign tgt_rsp[TGT_IFUERR] = '{err: 1'b1, rdata: '0};

  assign tgt_rsp[TGT_PPI]   = i_ppi_rsp;
  assign tgt_rsp[TGT_CLINT] = i_clint_rsp;
  assign tgt_rsp[TGT_PLIC]  = i_plic_rsp;
  assign tgt_rsp[TGT_MEM]   = i_mem_rsp;

  assign tgt_rsp_valid = {err_rsp_valid, i_ppi_rsp_valid, i_clint_rsp_valid,
                          i_plic_rsp_valid, i_mem_rsp_valid};

  // Current decode covers a same-cycle response
  assign rsp_sel  = busy ? sel_q : cmd_sel;
  assign rsp_live = busy | i_cmd_valid;

  assign o_rsp_valid = rsp_live & tgt_rsp_valid[rsp_sel];
  assign o_rsp       = tgt_rsp[rsp_sel];
  assign rsp_xfer    = o_rsp_valid & i_rsp_ready;

  assign o_ppi_rsp_ready   = rsp_live & i_rsp_ready & (rsp_sel == TGT_PPI);
  assign o_clint_rsp_ready = rsp_live & i_rsp_ready & (rsp_sel == TGT_CLINT);
  assign o_plic_rsp_ready  = rsp_live & i_rsp_ready & (rsp_sel == TGT_PLIC);
  assign o_mem_rsp_ready   = rsp_live & i_rsp_ready & (rsp_sel == TGT_MEM);

  ////////////////////////////////////////////////////////////
  // One outstanding, target held until its response leaves
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy  <= 1'b0;
      sel_q <= TGT_MEM;
    end else if (rsp_xfer) begin
      busy <= 1'b0;
    end else if (cmd_xfer) begin
      busy  <= 1'b1;
      sel_q <= cmd_sel;
    end
  end

endmodule

// ==== hdl/biu_buffer.sv ====
// Command and response pipe stages with an outstanding-transaction counter
`timescale 1ns/1ps

module biu_buffer import biu_pkg::*; (
  input  logic         clk,
  input  logic         i_arst_n,
  // Upstream, from the arbiter
  input  logic         i_cmd_valid,
  output logic         o_cmd_ready,
  input  icb_cmd_usr_t i_cmd,
  output logic         o_rsp_valid,
  input  logic         i_rsp_ready,
  output icb_rsp_t     o_rsp,
  // Downstream, to the splitter
  output logic         o_cmd_valid,
  input  logic         i_cmd_ready,
  output icb_cmd_usr_t o_cmd,
  input  logic         i_rsp_valid,
  output logic         o_rsp_ready,
  input  icb_rsp_t     i_rsp,
  output logic         o_active
);

  // One outstanding at most, upper bit is headroom
  logic [1:0] outs_cnt;
  logic       cmd_in;
  logic       rsp_out;

  biu_pipe_stage #(
    .T (icb_cmd_usr_t)
  ) u_cmd_stage (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_cmd_valid),
    .o_ready  (o_cmd_ready),
    .i_data   (i_cmd),
    .o_valid  (o_cmd_valid),
    .i_ready  (i_cmd_ready),
    .o_data   (o_cmd)
  );

  biu_pipe_stage #(
    .T (icb_rsp_t)
  ) u_rsp_stage (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_rsp_valid),
    .o_ready  (o_rsp_ready),
    .i_data   (i_rsp),
    .o_valid  (o_rsp_valid),
    .i_ready  (i_rsp_ready),
    .o_data   (o_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Accepted but not yet answered
  assign cmd_in  = i_cmd_valid & o_cmd_ready;
  assign rsp_out = o_rsp_valid & i_rsp_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      outs_cnt <= 2'd0;
    end else if (cmd_in && !rsp_out) begin
      outs_cnt <= outs_cnt + 2'd1;
    end else if (rsp_out && !cmd_in) begin
      outs_cnt <= outs_cnt - 2'd1;
    end
  end

  assign o_active = |outs_cnt;

endmodule

// ==== hdl/biu_arbiter.sv ====
// Fixed-priority LSU/IFU arbiter with one-outstanding tracking and response return
`timescale 1ns/1ps

module biu_arbiter import biu_pkg::*; (
  input  logic         clk,
  input  logic         i_arst_n,
  // LSU master
  input  logic         i_lsu_cmd_valid,
  output logic         o_lsu_cmd_ready,
  input  icb_cmd_t     i_lsu_cmd,
  output logic         o_lsu_rsp_valid,
  input  logic         i_lsu_rsp_ready,
  output icb_rsp_t     o_lsu_rsp,
  // IFU master
  input  logic         i_ifu_cmd_valid,
  output logic         o_ifu_cmd_ready,
  input  icb_cmd_t     i_ifu_cmd,
  output logic         o_ifu_rsp_valid,
  input  logic         i_ifu_rsp_ready,
  output icb_rsp_t     o_ifu_rsp,
  // Arbitrated bus towards the buffer
  output logic         o_cmd_valid,
  input  logic         i_cmd_ready,
  output icb_cmd_usr_t o_cmd,
  input  logic         i_rsp_valid,
  output logic         o_rsp_ready,
  input  icb_rsp_t     i_rsp
);

  logic outstanding;
  logic owner_ifu;
  logic grant_ifu;
  logic cmd_xfer;
  logic rsp_xfer;

  ////////////////////////////////////////////////////////////
  // Command side

  // LSU always wins, IFU only when LSU is idle
  assign grant_ifu = ~i_lsu_cmd_valid;

  assign o_cmd_valid = ~outstanding & (i_lsu_cmd_valid | i_ifu_cmd_valid);
  assign o_cmd.cmd   = grant_ifu ? i_ifu_cmd : i_lsu_cmd;
  assign o_cmd.ifu   = grant_ifu;

  assign o_lsu_cmd_ready = ~outstanding & i_cmd_ready;
  assign o_ifu_cmd_ready = ~outstanding & i_cmd_ready & grant_ifu;

  assign cmd_xfer = o_cmd_valid & i_cmd_ready;

  ////////////////////////////////////////////////////////////
  // Response side

  // Only the recorded owner sees the response
  assign o_lsu_rsp_valid = i_rsp_valid & ~owner_ifu;
  assign o_ifu_rsp_valid = i_rsp_valid & owner_ifu;
  assign o_lsu_rsp       = i_rsp;
  assign o_ifu_rsp       = i_rsp;
  assign o_rsp_ready     = owner_ifu ? i_ifu_rsp_ready : i_lsu_rsp_ready;

  assign rsp_xfer = i_rsp_valid & o_rsp_ready;

  ////////////////////////////////////////////////////////////
  // Outstanding flag and owner

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      outstanding <= 1'b0;
      owner_ifu   <= 1'b0;
    end else if (cmd_xfer) begin
      outstanding <= 1'b1;
      owner_ifu   <= grant_ifu;
    end else if (rsp_xfer) begin
      outstanding <= 1'b0;
    end
  end

endmodule

// ==== hdl/biu_pipe_stage.sv ====
// One-entry registered valid/ready stage with a type-parameter payload
`timescale 1ns/1ps

module biu_pipe_stage #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic i_arst_n,
  // Upstream side
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  // Downstream side
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  logic full;
  T     data_q;

  // Slot fills only when empty, so ready never depends on i_ready
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (i_valid && !full) begin
      full <= 1'b1;
    end else if (full && i_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && !full) begin
      data_q <= i_data;
    end
  end

  assign o_ready = ~full;
  assign o_valid = full;
  assign o_data  = data_q;

endmodule

// ==== hdl/biu_pkg.sv ====
// Bus interface unit widths, region match widths, target indices and ICB payload structs
package biu_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;

  // Top address bits compared per peripheral region
  localparam int PPI_MATCH_W   = 4;
  localparam int PLIC_MATCH_W  = 8;
  localparam int CLINT_MATCH_W = 16;

  // Four external targets plus the IFU error responder
  localparam int NUM_TARGETS = 5;

  ////////////////////////////////////////////////////////////
  // Splitter target index, also the bit position in the splitter vectors
  typedef enum logic [2:0] {
    TGT_MEM    = 3'd0,
    TGT_PLIC   = 3'd1,
    TGT_CLINT  = 3'd2,
    TGT_PPI    = 3'd3,
    TGT_IFUERR = 3'd4
  } target_e;

  ////////////////////////////////////////////////////////////
  // ICB payloads
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              read;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] wmask;
  } icb_cmd_t;

  // Command tagged with its source, set by the arbiter
  typedef struct packed {
    icb_cmd_t cmd;
    logic     ifu;
  } icb_cmd_usr_t;

  typedef struct packed {
    logic              err;
    logic [DATA_W-1:0] rdata;
  } icb_rsp_t;

endpackage
